// ==== all.f ====
hw/regfile_cfg_pkg.sv
hw/regfile_arb_pkg.sv
hw/bank_port_decode.sv
hw/regfile_bank_array.sv
hw/read_align.sv
hw/banked_regfile_top.sv
sim/banked_regfile_sva.sv
sim/banked_regfile_tb.sv

// ==== hw/bank_port_decode.sv ====
`timescale 1ns/1ps

module bank_port_decode
(
   input  logic                                                   wr0_en_i,
   input  regfile_cfg_pkg::reg_addr_t                             wr0_addr_i,
   input  regfile_cfg_pkg::word_t                                 wr0_data_i,

   input  regfile_cfg_pkg::lane_en_t                              wr1_en_i,
   input  regfile_cfg_pkg::reg_addr_t                             wr1_addr_i,
   input  regfile_cfg_pkg::wide_word_t                            wr1_data_i,

   input  regfile_cfg_pkg::reg_addr_t                             rd0_addr_i,
   input  regfile_cfg_pkg::reg_addr_t                             rd1_addr_i,
   input  regfile_cfg_pkg::reg_addr_t                             rd2_addr_i,

   output regfile_cfg_pkg::row_t  [regfile_cfg_pkg::NUM_BANKS-1:0] bank_row_o,
   output regfile_cfg_pkg::word_t [regfile_cfg_pkg::NUM_BANKS-1:0] bank_wdata_o,
   output logic                   [regfile_cfg_pkg::NUM_BANKS-1:0] bank_we_o
);
   import regfile_cfg_pkg::*;
   import regfile_arb_pkg::*;

   bank_sel_t wr0_bank;
   bank_sel_t wr1_base;
   bank_sel_t rd0_base;
   bank_sel_t rd1_bank;
   bank_sel_t rd2_bank;

   row_t      wr0_row;
   row_t      wr1_row;
   row_t      rd0_row;
   row_t      rd1_row;
   row_t      rd2_row;

   assign wr0_bank = bank_of(wr0_addr_i);
   assign wr1_base = bank_of(wr1_addr_i);
   assign rd0_base = bank_of(rd0_addr_i);
   assign rd1_bank = bank_of(rd1_addr_i);
   assign rd2_bank = bank_of(rd2_addr_i);

   // all lanes of a wide access share one row
   assign wr0_row = row_of(wr0_addr_i);
   assign wr1_row = row_of(wr1_addr_i);
   assign rd0_row = row_of(rd0_addr_i);
   assign rd1_row = row_of(rd1_addr_i);
   assign rd2_row = row_of(rd2_addr_i);

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      logic [NUM_REQ-1:0] req;
      bank_owner_e        owner;
      row_t               row;
      word_t              wdata;

      // who wants this bank, bit order follows the owner enum
      always_comb
      begin
         req[OWN_WR0 - 1] = wr0_en_i && (wr0_bank == bank_sel_t'(b));
         for (int k = 0; k < WIDE_LANES; k++)
         begin
            req[OWN_WR1_L0 - 1 + k] =
               wr1_en_i[k] && (lane_bank(wr1_base, k) == bank_sel_t'(b));
         end
         // reads are requested every cycle
         req[OWN_RD0_L0 - 1] = (rd0_base == bank_sel_t'(b));
         req[OWN_RD1 - 1]    = (rd1_bank == bank_sel_t'(b));
         req[OWN_RD2 - 1]    = (rd2_bank == bank_sel_t'(b));
         for (int k = 1; k < WIDE_LANES; k++)
         begin
            req[OWN_RD0_L1 - 2 + k] = (lane_bank(rd0_base, k) == bank_sel_t'(b));
         end
      end

      assign owner = pick_owner(req);

      // route the winner's row and data to the bank
      always_comb
      begin
         logic [1:0] wr1_lane;
         wr1_lane = 2'(owner - OWN_WR1_L0);
         row      = rd0_row;
         wdata    = wr0_data_i;
         case (owner)
            OWN_WR0:
            begin
               row = wr0_row;
            end
            OWN_WR1_L0, OWN_WR1_L1, OWN_WR1_L2, OWN_WR1_L3:
            begin
               row   = wr1_row;
               wdata = wr1_data_i[wr1_lane*WORD_W +: WORD_W];
            end
            OWN_RD1:
            begin
               row = rd1_row;
            end
            OWN_RD2:
            begin
               row = rd2_row;
            end
            // rd0 lanes and an idle bank both use rd0's row
            default:
            begin
               row = rd0_row;
            end
         endcase
      end

      assign bank_row_o[b]   = row;
      assign bank_wdata_o[b] = wdata;
      assign bank_we_o[b]    = is_write_owner(owner);
   end

endmodule

// ==== hw/banked_regfile_top.sv ====
`timescale 1ns/1ps

module banked_regfile_top
(
   input  logic                        CE_i,
   input  logic                        reset_i,

   // narrow write port
   input  logic                        wr0_en_i,
   input  regfile_cfg_pkg::reg_addr_t  wr0_addr_i,
   input  regfile_cfg_pkg::word_t      wr0_data_i,

   // wide write port with per-lane enable
   input  regfile_cfg_pkg::lane_en_t   wr1_en_i,
   input  regfile_cfg_pkg::reg_addr_t  wr1_addr_i,
   input  regfile_cfg_pkg::wide_word_t wr1_data_i,

   input  regfile_cfg_pkg::reg_addr_t  rd0_addr_i,
   input  regfile_cfg_pkg::reg_addr_t  rd1_addr_i,
   input  regfile_cfg_pkg::reg_addr_t  rd2_addr_i,

   output regfile_cfg_pkg::wide_word_t rd0_data_o,
   output regfile_cfg_pkg::word_t      rd1_data_o,
   output regfile_cfg_pkg::word_t      rd2_data_o
);
   import regfile_cfg_pkg::*;

   row_t  [NUM_BANKS-1:0] bank_row;
   word_t [NUM_BANKS-1:0] bank_wdata;
   logic  [NUM_BANKS-1:0] bank_we;
   word_t [NUM_BANKS-1:0] bank_rdata;

   bank_port_decode i_bank_port_decode (
      .wr0_en_i     (wr0_en_i),
      .wr0_addr_i   (wr0_addr_i),
      .wr0_data_i   (wr0_data_i),
      .wr1_en_i     (wr1_en_i),
      .wr1_addr_i   (wr1_addr_i),
      .wr1_data_i   (wr1_data_i),
      .rd0_addr_i   (rd0_addr_i),
      .rd1_addr_i   (rd1_addr_i),
      .rd2_addr_i   (rd2_addr_i),
      .bank_row_o   (bank_row),
      .bank_wdata_o (bank_wdata),
      .bank_we_o    (bank_we)
   );

   regfile_bank_array i_regfile_bank_array (
      .CE_i         (CE_i),
      .reset_i      (reset_i),
      .bank_row_i   (bank_row),
      .bank_wdata_i (bank_wdata),
      .bank_we_i    (bank_we),
      .bank_rdata_o (bank_rdata)
   );

   // read addresses go straight in, selects are registered inside
   read_align i_read_align (
      .CE_i         (CE_i),
      .reset_i      (reset_i),
      .rd0_addr_i   (rd0_addr_i),
      .rd1_addr_i   (rd1_addr_i),
      .rd2_addr_i   (rd2_addr_i),
      .bank_rdata_i (bank_rdata),
      .rd0_data_o   (rd0_data_o),
      .rd1_data_o   (rd1_data_o),
      .rd2_data_o   (rd2_data_o)
   );

endmodule

// ==== hw/read_align.sv ====
`timescale 1ns/1ps

module read_align
(
   input  logic                                                   CE_i,
   input  logic                                                   reset_i,

   input  regfile_cfg_pkg::reg_addr_t                             rd0_addr_i,
   input  regfile_cfg_pkg::reg_addr_t                             rd1_addr_i,
   input  regfile_cfg_pkg::reg_addr_t                             rd2_addr_i,

   input  regfile_cfg_pkg::word_t [regfile_cfg_pkg::NUM_BANKS-1:0] bank_rdata_i,

   output regfile_cfg_pkg::wide_word_t                            rd0_data_o,
   output regfile_cfg_pkg::word_t                                 rd1_data_o,
   output regfile_cfg_pkg::word_t                                 rd2_data_o
);
   import regfile_cfg_pkg::*;

   bank_sel_t rd0_sel_q;
   bank_sel_t rd1_sel_q;
   bank_sel_t rd2_sel_q;

   // bank indices captured on the same edge as the bank read
   always_ff @(posedge CE_i)
   begin
      if (reset_i)
      begin
         rd0_sel_q <= '0;
         rd1_sel_q <= '0;
         rd2_sel_q <= '0;
      end
      else
      begin
         rd0_sel_q <= bank_of(rd0_addr_i);
         rd1_sel_q <= bank_of(rd1_addr_i);
         rd2_sel_q <= bank_of(rd2_addr_i);
      end
   end

   // rotate the banks so lane k of rd0 gets bank (base + k) mod 16
   for (genvar k = 0; k < WIDE_LANES; k++)
   begin : g_rd0_lane
      bank_sel_t lane_sel;

      assign lane_sel = lane_bank(rd0_sel_q, k);
      assign rd0_data_o[k*WORD_W +: WORD_W] = bank_rdata_i[lane_sel];
   end

   // narrow ports pick a single bank
   assign rd1_data_o = bank_rdata_i[rd1_sel_q];
   assign rd2_data_o = bank_rdata_i[rd2_sel_q];

endmodule

// ==== hw/regfile_arb_pkg.sv ====
package regfile_arb_pkg;

   // bank owners, highest priority first after idle
   typedef enum logic [3:0] {
      OWN_IDLE,
      OWN_WR0,
      OWN_WR1_L0,
      OWN_WR1_L1,
      OWN_WR1_L2,
      OWN_WR1_L3,
      OWN_RD0_L0,
      OWN_RD1,
      OWN_RD2,
      OWN_RD0_L1,
      OWN_RD0_L2,
      OWN_RD0_L3
   } bank_owner_e;

   // owners up to this one write the bank, the rest only read
   localparam bank_owner_e OWNER_IS_WRITE = OWN_WR1_L3;

   // one request bit per owner, bit i stands for owner value i+1
   localparam int NUM_REQ = 11;

   // lowest set bit wins
   function automatic bank_owner_e pick_owner(logic [NUM_REQ-1:0] req);
      bank_owner_e owner;
      owner = OWN_IDLE;
      for (int i = NUM_REQ - 1; i >= 0; i--)
      begin
         if (req[i])
         begin
            owner = bank_owner_e'(i + 1);
         end
      end
      return owner;
   endfunction

   function automatic logic is_write_owner(bank_owner_e owner);
      return (owner != OWN_IDLE) && (owner <= OWNER_IS_WRITE);
   endfunction

endpackage

// ==== hw/regfile_bank_array.sv ====
`timescale 1ns/1ps

module regfile_bank_array
(
   input  logic                                                   CE_i,
   input  logic                                                   reset_i,

   input  regfile_cfg_pkg::row_t  [regfile_cfg_pkg::NUM_BANKS-1:0] bank_row_i,
   input  regfile_cfg_pkg::word_t [regfile_cfg_pkg::NUM_BANKS-1:0] bank_wdata_i,
   input  logic                   [regfile_cfg_pkg::NUM_BANKS-1:0] bank_we_i,

   output regfile_cfg_pkg::word_t [regfile_cfg_pkg::NUM_BANKS-1:0] bank_rdata_o
);
   import regfile_cfg_pkg::*;

   // one single-port memory per bank
   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      word_t mem [ROWS_PER_BANK];
      word_t rdata_q;

      // storage array, contents survive reset
      always_ff @(posedge CE_i)
      begin
         if (bank_we_i[b])
         begin
            mem[bank_row_i[b]] <= bank_wdata_i[b];
         end
      end

      // output register, a write shows the new word straight away
      always_ff @(posedge CE_i)
      begin
         if (reset_i)
         begin
            rdata_q <= '0;
         end
         else if (bank_we_i[b])
         begin
            rdata_q <= bank_wdata_i[b];
         end
         else
         begin
            rdata_q <= mem[bank_row_i[b]];
         end
      end

      assign bank_rdata_o[b] = rdata_q;
   end

endmodule

// ==== hw/regfile_cfg_pkg.sv ====
package regfile_cfg_pkg;

   // register file geometry
   localparam int ADDR_W        = 10;
   localparam int WORD_W        = 32;
   localparam int NUM_BANKS     = 16;
   localparam int BANK_SEL_W    = 4;
   localparam int ROW_W         = 6;
   localparam int ROWS_PER_BANK = 1 << ROW_W;

   // words moved by rd0 and wr1 in one access
   localparam int WIDE_LANES = 4;

   typedef logic [ADDR_W-1:0]            reg_addr_t;
   typedef logic [WORD_W-1:0]            word_t;
   typedef logic [BANK_SEL_W-1:0]        bank_sel_t;
   typedef logic [ROW_W-1:0]             row_t;
   typedef logic [WIDE_LANES-1:0]        lane_en_t;

   // lane k sits in bits 32k upward
   typedef logic [WIDE_LANES*WORD_W-1:0] wide_word_t;

   // bank index is the low address bits
   function automatic bank_sel_t bank_of(reg_addr_t addr);
      return addr[BANK_SEL_W-1:0];
   endfunction

   // row is the high address bits
   function automatic row_t row_of(reg_addr_t addr);
      return addr[ADDR_W-1 -: ROW_W];
   endfunction

   // bank of wide lane k, wrapping past the last bank
   function automatic bank_sel_t lane_bank(bank_sel_t base, int unsigned lane);
      return bank_sel_t'(base + lane);
   endfunction

endpackage

// ==== sim/banked_regfile_sva.sv ====
`timescale 1ns/1ps

module banked_regfile_sva
(
   input  logic                                                   CE_i,
   input  logic                                                   reset_i,
   input  logic                                                   wr0_en_i,
   input  regfile_cfg_pkg::reg_addr_t                             wr0_addr_i,
   input  regfile_cfg_pkg::word_t                                 wr0_data_i,
   input  regfile_cfg_pkg::lane_en_t                              wr1_en_i,
   input  regfile_cfg_pkg::reg_addr_t                             wr1_addr_i,
   input  regfile_cfg_pkg::wide_word_t                            wr1_data_i,
   input  regfile_cfg_pkg::word_t [regfile_cfg_pkg::NUM_BANKS-1:0] bank_wdata_i,
   input  logic                   [regfile_cfg_pkg::NUM_BANKS-1:0] bank_we_i,
   input  regfile_cfg_pkg::wide_word_t                            rd0_data_i,
   input  regfile_cfg_pkg::word_t                                 rd1_data_i,
   input  regfile_cfg_pkg::word_t                                 rd2_data_i
);
   import regfile_cfg_pkg::*;
   import regfile_arb_pkg::*;

   // assertion failures so far
   int fail_count = 0;

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      bank_owner_e writer;
      word_t       writer_data;

      // highest priority write requester on this bank, wr0 ahead of wr1 lanes
      always_comb
      begin
         int k;
         writer      = OWN_IDLE;
         writer_data = '0;
         for (k = WIDE_LANES - 1; k >= 0; k--)
         begin
            if (wr1_en_i[k] && (((int'(wr1_addr_i[BANK_SEL_W-1:0]) + k) % NUM_BANKS) == b))
            begin
               writer      = bank_owner_e'(int'(OWN_WR1_L0) + k);
               writer_data = wr1_data_i[k*WORD_W +: WORD_W];
            end
         end
         if (wr0_en_i && (int'(wr0_addr_i[BANK_SEL_W-1:0]) == b))
         begin
            writer      = OWN_WR0;
            writer_data = wr0_data_i;
         end
      end

      a_we_needs_writer: assert property (@(posedge CE_i) disable iff (reset_i)
         bank_we_i[b] |-> (writer != OWN_IDLE) && (writer <= OWNER_IS_WRITE))
         else
         begin
            $error("bank %0d write enable without a write owner", b);
            fail_count++;
         end

      // only the winning writer's word reaches the bank
      a_one_writer: assert property (@(posedge CE_i) disable iff (reset_i)
         (writer != OWN_IDLE) |-> bank_we_i[b] && (bank_wdata_i[b] == writer_data))
         else
         begin
            $error("bank %0d written with a word other than its owner's", b);
            fail_count++;
         end
   end

   a_zero_after_reset: assert property (@(posedge CE_i)
      $fell(reset_i) |-> (rd0_data_i == '0) && (rd1_data_i == '0) && (rd2_data_i == '0))
      else
      begin
         $error("read outputs not zero in the first cycle after reset");
         fail_count++;
      end

endmodule

// ==== sim/banked_regfile_tb.sv ====
`timescale 1ns/1ps

module banked_regfile_tb;
   import regfile_cfg_pkg::*;

   localparam int HALF_PERIOD  = 2;
   localparam int RESET_CYCLES = 2;
   localparam int RESET_LIMIT  = 20;
   localparam int NUM_WORDS    = 1024;
   localparam int NUM_REQS     = 11;

   typedef struct {
      logic       wr0_en;
      reg_addr_t  wr0_addr;
      word_t      wr0_data;
      lane_en_t   wr1_en;
      reg_addr_t  wr1_addr;
      wide_word_t wr1_data;
      reg_addr_t  rd0_addr;
      reg_addr_t  rd1_addr;
      reg_addr_t  rd2_addr;
      bit         check;
   } stim_t;

   logic       CE_i       = 1'b0;
   logic       reset_i    = 1'b1;
   logic       wr0_en_i   = 1'b0;
   reg_addr_t  wr0_addr_i = '0;
   word_t      wr0_data_i = '0;
   lane_en_t   wr1_en_i   = '0;
   reg_addr_t  wr1_addr_i = '0;
   wide_word_t wr1_data_i = '0;
   reg_addr_t  rd0_addr_i = '0;
   reg_addr_t  rd1_addr_i = '0;
   reg_addr_t  rd2_addr_i = '0;
   wide_word_t rd0_data_o;
   word_t      rd1_data_o;
   word_t      rd2_data_o;

   stim_t      stim_rows [$];
   word_t      ref_mem [NUM_WORDS];
   int         seed;
   int         errors;
   int         checks;
   bit         timed_out;

   banked_regfile_top i_banked_regfile_top (
      .CE_i       (CE_i),
      .reset_i    (reset_i),
      .wr0_en_i   (wr0_en_i),
      .wr0_addr_i (wr0_addr_i),
      .wr0_data_i (wr0_data_i),
      .wr1_en_i   (wr1_en_i),
      .wr1_addr_i (wr1_addr_i),
      .wr1_data_i (wr1_data_i),
      .rd0_addr_i (rd0_addr_i),
      .rd1_addr_i (rd1_addr_i),
      .rd2_addr_i (rd2_addr_i),
      .rd0_data_o (rd0_data_o),
      .rd1_data_o (rd1_data_o),
      .rd2_data_o (rd2_data_o)
   );

   bind banked_regfile_top banked_regfile_sva i_banked_regfile_sva (
      .CE_i         (CE_i),
      .reset_i      (reset_i),
      .wr0_en_i     (wr0_en_i),
      .wr0_addr_i   (wr0_addr_i),
      .wr0_data_i   (wr0_data_i),
      .wr1_en_i     (wr1_en_i),
      .wr1_addr_i   (wr1_addr_i),
      .wr1_data_i   (wr1_data_i),
      .bank_wdata_i (bank_wdata),
      .bank_we_i    (bank_we),
      .rd0_data_i   (rd0_data_o),
      .rd1_data_i   (rd1_data_o),
      .rd2_data_i   (rd2_data_o)
   );

   always #HALF_PERIOD CE_i = ~CE_i;

   // register address from row and bank
   function automatic reg_addr_t mk_addr(int row, int bank);
      return reg_addr_t'(row * NUM_BANKS + bank);
   endfunction

   // word k of a wide access, same row, bank wraps around
   function automatic reg_addr_t lane_addr(reg_addr_t base, int k);
      return reg_addr_t'((base / NUM_BANKS) * NUM_BANKS + ((base % NUM_BANKS) + k) % NUM_BANKS);
   endfunction

   function automatic word_t rand_word();
      return $random(seed);
   endfunction

   task automatic add_row(input logic wr0_en, input reg_addr_t wr0_addr,
                          input lane_en_t wr1_en, input reg_addr_t wr1_addr,
                          input reg_addr_t rd0_addr, input reg_addr_t rd1_addr,
                          input reg_addr_t rd2_addr, input bit check);
      stim_t s;
      s.wr0_en   = wr0_en;
      s.wr0_addr = wr0_addr;
      s.wr0_data = rand_word();
      s.wr1_en   = wr1_en;
      s.wr1_addr = wr1_addr;
      s.wr1_data = {rand_word(), rand_word(), rand_word(), rand_word()};
      s.rd0_addr = rd0_addr;
      s.rd1_addr = rd1_addr;
      s.rd2_addr = rd2_addr;
      s.check    = check;
      stim_rows.push_back(s);
   endtask

   task automatic build_table();
      int r;
      int q;
      // fill every word first so later reads are defined
      for (r = 0; r < 64; r++)
      begin
         for (q = 0; q < 4; q++)
         begin
            add_row(1'b0, '0, 4'b1111, mk_addr(r, 4 * q), '0, '0, '0, 1'b0);
         end
      end
      // wr0 singles, read back on rd1 and rd2
      add_row(1'b1, mk_addr(3, 5), 4'b0, '0, mk_addr(2, 11), mk_addr(0, 7), mk_addr(1, 8), 1'b1);
      add_row(1'b1, mk_addr(10, 2), 4'b0, '0, mk_addr(2, 11), mk_addr(3, 5), mk_addr(5, 3), 1'b1);
      add_row(1'b1, mk_addr(40, 9), 4'b0, '0, mk_addr(2, 11), mk_addr(10, 2), mk_addr(3, 5), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(2, 11), mk_addr(40, 9), mk_addr(10, 2), 1'b1);
      // unaligned wr1 from bank 14, lane 2 (bank 0) disabled
      add_row(1'b0, '0, 4'b1011, mk_addr(20, 14), mk_addr(2, 4), mk_addr(6, 8), mk_addr(7, 9), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(20, 14), mk_addr(6, 8), mk_addr(7, 9), 1'b1);
      // wr0 and wr1 on disjoint banks
      add_row(1'b1, mk_addr(7, 3), 4'b1111, mk_addr(9, 8), mk_addr(2, 12), '0, mk_addr(0, 1), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(9, 8), mk_addr(7, 3), mk_addr(0, 1), 1'b1);
      // wr0 and wr1 lane 2 both on bank 6
      add_row(1'b1, mk_addr(12, 6), 4'b1111, mk_addr(30, 4), mk_addr(2, 12), '0, mk_addr(0, 1), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(30, 4), '0, mk_addr(0, 1), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(2, 12), mk_addr(12, 6), mk_addr(0, 1), 1'b1);
      // rd1 and rd0 lane 1 meet on bank 5 at different rows
      add_row(1'b0, '0, 4'b0, '0, mk_addr(33, 4), mk_addr(50, 5), mk_addr(0, 9), 1'b1);
      // write-through, then the same row one cycle later
      add_row(1'b1, mk_addr(15, 12), 4'b0, '0, mk_addr(2, 0), mk_addr(15, 12), mk_addr(8, 12), 1'b1);
      add_row(1'b0, '0, 4'b0, '0, mk_addr(2, 0), mk_addr(15, 12), mk_addr(15, 12), 1'b1);
   endtask

   task automatic apply_row(input stim_t s);
      wr0_en_i   <= s.wr0_en;
      wr0_addr_i <= s.wr0_addr;
      wr0_data_i <= s.wr0_data;
      wr1_en_i   <= s.wr1_en;
      wr1_addr_i <= s.wr1_addr;
      wr1_data_i <= s.wr1_data;
      rd0_addr_i <= s.rd0_addr;
      rd1_addr_i <= s.rd1_addr;
      rd2_addr_i <= s.rd2_addr;
   endtask

   // one cycle of the reference: arbitration, writes and the words each read port sees
   task automatic model_step(input stim_t s, output wide_word_t e_rd0,
                             output word_t e_rd1, output word_t e_rd2);
      reg_addr_t req_addr  [NUM_REQS];
      bit        req_on    [NUM_REQS];
      bit        req_wr    [NUM_REQS];
      word_t     req_data  [NUM_REQS];
      bit        bank_busy [NUM_BANKS];
      word_t     bank_out  [NUM_BANKS];
      int        i;
      int        k;
      int        bank;
      for (i = 0; i < NUM_REQS; i++)
      begin
         req_on[i]   = 1'b1;
         req_wr[i]   = 1'b0;
         req_addr[i] = '0;
         req_data[i] = '0;
      end
      // priority order wr0, wr1 lanes, rd0 lane 0, rd1, rd2, rd0 lanes 1 to 3
      req_on[0]   = s.wr0_en;
      req_wr[0]   = 1'b1;
      req_addr[0] = s.wr0_addr;
      req_data[0] = s.wr0_data;
      for (k = 0; k < WIDE_LANES; k++)
      begin
         req_on[1 + k]   = s.wr1_en[k];
         req_wr[1 + k]   = 1'b1;
         req_addr[1 + k] = lane_addr(s.wr1_addr, k);
         req_data[1 + k] = s.wr1_data[k*WORD_W +: WORD_W];
      end
      req_addr[5] = s.rd0_addr;
      req_addr[6] = s.rd1_addr;
      req_addr[7] = s.rd2_addr;
      for (k = 1; k < WIDE_LANES; k++)
      begin
         req_addr[7 + k] = lane_addr(s.rd0_addr, k);
      end
      for (i = 0; i < NUM_BANKS; i++)
      begin
         bank_busy[i] = 1'b0;
         bank_out[i]  = '0;
      end
      for (i = 0; i < NUM_REQS; i++)
      begin
         bank = req_addr[i] % NUM_BANKS;
         if (req_on[i] && !bank_busy[bank])
         begin
            bank_busy[bank] = 1'b1;
            if (req_wr[i])
            begin
               ref_mem[req_addr[i]] = req_data[i];
               bank_out[bank]       = req_data[i];
            end
            else
            begin
               bank_out[bank] = ref_mem[req_addr[i]];
            end
         end
      end
      // every read port takes whatever its bank produced
      for (k = 0; k < WIDE_LANES; k++)
      begin
         e_rd0[k*WORD_W +: WORD_W] = bank_out[lane_addr(s.rd0_addr, k) % NUM_BANKS];
      end
      e_rd1 = bank_out[s.rd1_addr % NUM_BANKS];
      e_rd2 = bank_out[s.rd2_addr % NUM_BANKS];
   endtask

   task automatic check_value(input string what, input logic [127:0] actual,
                              input logic [127:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("error at %0d ns: %s got %h expected %h", $time, what, actual, expected);
      end
   endtask

   initial
   begin
      int         cycles;
      int         limit;
      int         i;
      int         sva_fails;
      bit         pend_check;
      wide_word_t nxt_rd0;
      word_t      nxt_rd1;
      word_t      nxt_rd2;
      wide_word_t pend_rd0;
      word_t      pend_rd1;
      word_t      pend_rd2;
      stim_t      idle_row;

      seed       = 91;
      errors     = 0;
      checks     = 0;
      timed_out  = 1'b0;
      pend_check = 1'b0;
      idle_row   = '{default: '0};
      build_table();

      cycles = 0;
      while (cycles < RESET_CYCLES && !timed_out)
      begin
         @(posedge CE_i);
         cycles++;
         if (cycles > RESET_LIMIT)
         begin
            timed_out = 1'b1;
            $display("timeout: reset did not finish within %0d cycles", RESET_LIMIT);
         end
      end
      reset_i <= 1'b0;
      @(negedge CE_i);
      check_value("rd0 after reset", rd0_data_o, '0);
      check_value("rd1 after reset", rd1_data_o, '0);
      check_value("rd2 after reset", rd2_data_o, '0);

      // outputs seen at a negedge belong to the row driven one cycle earlier
      cycles = 0;
      limit  = stim_rows.size() + 16;
      for (i = 0; i < stim_rows.size() && !timed_out; i++)
      begin
         @(posedge CE_i);
         apply_row(stim_rows[i]);
         model_step(stim_rows[i], nxt_rd0, nxt_rd1, nxt_rd2);
         @(negedge CE_i);
         if (pend_check)
         begin
            check_value("rd0", rd0_data_o, pend_rd0);
            check_value("rd1", rd1_data_o, pend_rd1);
            check_value("rd2", rd2_data_o, pend_rd2);
         end
         pend_check = stim_rows[i].check;
         pend_rd0   = nxt_rd0;
         pend_rd1   = nxt_rd1;
         pend_rd2   = nxt_rd2;
         cycles++;
         if (cycles > limit)
         begin
            timed_out = 1'b1;
            $display("timeout: stimulus table ran past %0d cycles", limit);
         end
      end

      if (!timed_out)
      begin
         @(posedge CE_i);
         apply_row(idle_row);
         @(negedge CE_i);
         if (pend_check)
         begin
            check_value("rd0", rd0_data_o, pend_rd0);
            check_value("rd1", rd1_data_o, pend_rd1);
            check_value("rd2", rd2_data_o, pend_rd2);
         end
      end

      sva_fails = i_banked_regfile_top.i_banked_regfile_sva.fail_count;
      $display("checks: %0d, errors: %0d, assertion failures: %0d, timed out: %0d",
               checks, errors, sva_fails, timed_out);
      if (errors == 0 && sva_fails == 0 && !timed_out)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
